//--- src/fetch_pkg.sv
package fetch_pkg;

    //////////////////////////////////////////////////////////////////////
    // buffer geometry
    //////////////////////////////////////////////////////////////////////

    localparam int num_lines     = 4;
    localparam int line_bytes    = 16;
    localparam int line_bits     = line_bytes * 8;
    localparam int buf_bytes     = num_lines * line_bytes;
    localparam int bip_bits      = 6;
    localparam int line_idx_bits = 2;

    // decode side
    localparam int len_bits = 8;
    localparam int max_len  = 16;

    //////////////////////////////////////////////////////////////////////
    // byte pointer
    //////////////////////////////////////////////////////////////////////

    // line index on top, byte within the line below
    typedef struct packed {
        logic [line_idx_bits-1:0]          line;
        logic [bip_bits-line_idx_bits-1:0] offset;
    } bip_split_t;

    // raw for add and rotate, split for valid check and release
    typedef union packed {
        logic [bip_bits-1:0] raw;
        bip_split_t          split;
    } bip_t;

endpackage

//--- src/ibuf_if.sv
`timescale 1ns/1ps

interface ibuf_if import fetch_pkg::*; ();

    // line 0 sits in the low 128 bits
    logic [num_lines-1:0][line_bits-1:0] lines;
    logic [num_lines-1:0]                line_valid;

    // back from fetch
    logic                     release_strobe;
    logic [line_idx_bits-1:0] release_line;
    logic                     flush;

    modport buffer (
        output lines,
        output line_valid,
        input  release_strobe,
        input  release_line,
        input  flush
    );

    modport fetch (
        input  line_valid,
        output release_strobe,
        output release_line,
        output flush
    );

    // rotator only reads the bytes
    modport window (
        input  lines
    );

endinterface

//--- src/instr_buffer.sv
`timescale 1ns/1ps

module instr_buffer import fetch_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,

    // fill side
    input  logic                     fill_strobe,
    input  logic [line_idx_bits-1:0] fill_line,
    input  logic [line_bits-1:0]     fill_data,

    ibuf_if.buffer                   bus
);

    //////////////////////////////////////////////////////////////////////
    // one-hot line selects
    //////////////////////////////////////////////////////////////////////

    logic [num_lines-1:0] fill_hit;
    logic [num_lines-1:0] release_hit;

    always_comb begin
        fill_hit = '0;
        if (fill_strobe) begin
            fill_hit[fill_line] = 1'b1;
        end
    end

    always_comb begin
        release_hit = '0;
        if (bus.release_strobe) begin
            release_hit[bus.release_line] = 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // per-line storage and valid
    //////////////////////////////////////////////////////////////////////

    logic [num_lines-1:0][line_bits-1:0] line_q;
    logic [num_lines-1:0]                valid_q;
    logic [num_lines-1:0]                valid_d;

    for (genvar i = 0; i < num_lines; i++) begin : g_line

        // fill beats flush, flush beats release
        always_comb begin
            if (fill_hit[i]) begin
                valid_d[i] = 1'b1;
            end else if (bus.flush) begin
                valid_d[i] = 1'b0;
            end else if (release_hit[i]) begin
                valid_d[i] = 1'b0;
            end else begin
                valid_d[i] = valid_q[i];
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                valid_q[i] <= 1'b0;
            end else begin
                valid_q[i] <= valid_d[i];
            end
        end

        // bytes only change on a fill
        always_ff @(posedge clk) begin
            if (fill_hit[i]) begin
                line_q[i] <= fill_data;
            end
        end

    end

    //////////////////////////////////////////////////////////////////////
    // to fetch and rotator
    //////////////////////////////////////////////////////////////////////

    assign bus.lines      = line_q;
    assign bus.line_valid = valid_q;

endmodule

//--- src/fetch_pointer.sv
`timescale 1ns/1ps

module fetch_pointer import fetch_pkg::*; (
    input  logic                clk,
    input  logic                reset,

    // decode
    input  logic [len_bits-1:0] length,
    input  logic                stall,

    // control flow sources, highest priority first
    input  bip_t                init_bip,
    input  logic                is_init,
    input  bip_t                wb_bip,
    input  logic                is_resteer,
    input  bip_t                bp_bip,
    input  logic                is_branch_taken,

    ibuf_if.fetch               bus,

    output bip_t                bip,
    output logic                packet_valid,
    output bip_t                new_bip
);

    //////////////////////////////////////////////////////////////////////
    // control flow select
    //////////////////////////////////////////////////////////////////////

    logic is_cf;
    bip_t cf_target;

    assign is_cf = is_init | is_resteer | is_branch_taken;

    always_comb begin
        if (is_init) begin
            cf_target = init_bip;
        end else if (is_resteer) begin
            cf_target = wb_bip;
        end else begin
            cf_target = bp_bip;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // length adder and window check
    //////////////////////////////////////////////////////////////////////

    logic [line_idx_bits-1:0] next_line;
    logic                     advance;

    // wraps modulo 64
    assign new_bip.raw = bip_bits'({{(len_bits-bip_bits){1'b0}}, bip.raw} + length);

    // window spans the current line and the one after it
    assign next_line    = bip.split.line + line_idx_bits'(1);
    assign packet_valid = bus.line_valid[bip.split.line] & bus.line_valid[next_line];

    assign advance = packet_valid & ~stall & ~is_cf;

    //////////////////////////////////////////////////////////////////////
    // BIP register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            bip.raw <= '0;
        end else if (is_cf) begin
            bip <= cf_target;
        end else if (advance) begin
            bip <= new_bip;
        end
    end

    // old line is freed once the pointer moves past it
    assign bus.release_strobe = advance & (new_bip.split.line != bip.split.line);
    assign bus.release_line   = bip.split.line;
    assign bus.flush          = is_cf;

endmodule

//--- src/byte_rotator.sv
`timescale 1ns/1ps

module byte_rotator import fetch_pkg::*; (
    ibuf_if.window               bus,
    input  bip_t                 bip,
    output logic [line_bits-1:0] packet
);

    //////////////////////////////////////////////////////////////////////
    // log rotator, one stage per pointer bit
    //////////////////////////////////////////////////////////////////////

    // stage 0 is the raw buffer, byte 0 of line 0 in bits 7:0
    logic [buf_bytes*8-1:0] stage [bip_bits+1];

    assign stage[0] = bus.lines;

    for (genvar s = 0; s < bip_bits; s++) begin : g_stage
        for (genvar j = 0; j < buf_bytes; j++) begin : g_byte

            // byte j pulls from byte j + 2^s when this bit is set
            localparam int src = (j + (1 << s)) % buf_bytes;

            assign stage[s+1][8*j +: 8] = bip.raw[s] ? stage[s][8*src +: 8]
                                                     : stage[s][8*j +: 8];
        end
    end

    // low 16 bytes now start at the BIP
    assign packet = stage[bip_bits][line_bits-1:0];

endmodule

//--- src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,

    // fill side
    input  logic                     fill_strobe,
    input  logic [line_idx_bits-1:0] fill_line,
    input  logic [line_bits-1:0]     fill_data,

    // decode
    input  logic [len_bits-1:0]      length,
    input  logic                     stall,

    // control flow
    input  logic [bip_bits-1:0]      init_bip,
    input  logic                     is_init,
    input  logic [bip_bits-1:0]      wb_bip,
    input  logic                     is_resteer,
    input  logic [bip_bits-1:0]      bp_bip,
    input  logic                     is_branch_taken,

    // to decode
    output logic [line_bits-1:0]     packet_out,
    output logic                     packet_out_valid,
    output logic [bip_bits-1:0]      old_bip,
    output logic [bip_bits-1:0]      new_bip
);

    //////////////////////////////////////////////////////////////////////
    // pointer views
    //////////////////////////////////////////////////////////////////////

    bip_t init_u;
    bip_t wb_u;
    bip_t bp_u;
    bip_t cur_u;
    bip_t next_u;

    assign init_u.raw = init_bip;
    assign wb_u.raw   = wb_bip;
    assign bp_u.raw   = bp_bip;

    assign old_bip = cur_u.raw;
    assign new_bip = next_u.raw;

    //////////////////////////////////////////////////////////////////////
    // stage
    //////////////////////////////////////////////////////////////////////

    ibuf_if ibuf ();

    instr_buffer u_instr_buffer (
        .clk         (clk),
        .reset       (reset),
        .fill_strobe (fill_strobe),
        .fill_line   (fill_line),
        .fill_data   (fill_data),
        .bus         (ibuf)
    );

    fetch_pointer u_fetch_pointer (
        .clk             (clk),
        .reset           (reset),
        .length          (length),
        .stall           (stall),
        .init_bip        (init_u),
        .is_init         (is_init),
        .wb_bip          (wb_u),
        .is_resteer      (is_resteer),
        .bp_bip          (bp_u),
        .is_branch_taken (is_branch_taken),
        .bus             (ibuf),
        .bip             (cur_u),
        .packet_valid    (packet_out_valid),
        .new_bip         (next_u)
    );

    byte_rotator u_byte_rotator (
        .bus    (ibuf),
        .bip    (cur_u),
        .packet (packet_out)
    );

endmodule

//--- verification/fetch_props.sv
`timescale 1ns/1ps

module fetch_props import fetch_pkg::*; (
    input logic                 clk,
    input logic                 reset,
    input logic [len_bits-1:0]  length,
    input logic                 stall,
    input logic                 is_cf,
    input logic                 packet_valid,
    input logic [bip_bits-1:0]  bip_raw,
    input logic [num_lines-1:0] line_valid,
    input logic                 flush
);

    int fail_count = 0;

    // decode never consumes more than one packet
    a_len_max: assert property (@(posedge clk) disable iff (reset)
        (packet_valid && !stall && !is_cf) |-> (int'(length) <= max_len))
        else begin
            fail_count++;
            $error("advance taken with a length above the packet size");
        end

    // flush empties the buffer apart from a same-cycle fill
    a_flush_clear: assert property (@(posedge clk) disable iff (reset)
        flush |=> ($countones(line_valid) <= 1))
        else begin
            fail_count++;
            $error("lines still valid in the cycle after a flush");
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        (stall && !is_cf) |=> $stable(bip_raw))
        else begin
            fail_count++;
            $error("pointer moved during a stall without control flow");
        end

endmodule

bind fetch_pointer fetch_props u_props (
    .clk          (clk),
    .reset        (reset),
    .length       (length),
    .stall        (stall),
    .is_cf        (is_cf),
    .packet_valid (packet_valid),
    .bip_raw      (bip.raw),
    .line_valid   (bus.line_valid),
    .flush        (bus.flush)
);

//--- verification/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker import fetch_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     fill_strobe,
    input  logic [line_idx_bits-1:0] fill_line,
    input  logic [line_bits-1:0]     fill_data,
    input  logic [len_bits-1:0]      length,
    input  logic                     stall,
    input  logic [bip_bits-1:0]      init_bip,
    input  logic                     is_init,
    input  logic [bip_bits-1:0]      wb_bip,
    input  logic                     is_resteer,
    input  logic [bip_bits-1:0]      bp_bip,
    input  logic                     is_branch_taken,
    input  logic [line_bits-1:0]     packet_out,
    input  logic                     packet_out_valid,
    input  logic [bip_bits-1:0]      old_bip,
    input  logic [bip_bits-1:0]      new_bip,
    output int                       check_count,
    output int                       error_count
);

    // byte-level image of the buffer
    logic [7:0]          mem [buf_bytes];
    logic [num_lines-1:0] m_valid;
    logic [bip_bits-1:0]  m_bip;

    initial begin
        check_count = 0;
        error_count = 0;
        m_valid     = '0;
        m_bip       = '0;
    end

    task automatic compare_value(input string name, input logic [line_bits-1:0] got,
                                 input logic [line_bits-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %s: got %0h expected %0h", name, got, exp);
        end
    endtask

    // table expectations sampled after the row's edge
    task automatic check_row(input int row, input logic [bip_bits-1:0] exp_bip,
                             input logic exp_valid);
        compare_value($sformatf("old_bip after row %0d", row), line_bits'(old_bip),
                      line_bits'(exp_bip));
        compare_value($sformatf("packet_out_valid after row %0d", row),
                      line_bits'(packet_out_valid), line_bits'(exp_valid));
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model checked and stepped on every edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin : model
        logic [line_idx_bits-1:0] cur_line;
        logic [line_idx_bits-1:0] nxt_line;
        int                       sum;
        logic                     exp_pv;
        logic [bip_bits-1:0]      exp_new;
        logic [bip_bits-1:0]      nxt;
        logic [line_bits-1:0]     exp_pkt;
        if (reset) begin
            m_bip   = '0;
            m_valid = '0;
        end else begin
            cur_line = line_idx_bits'(int'(m_bip) / line_bytes);
            nxt_line = line_idx_bits'((int'(cur_line) + 1) % num_lines);
            exp_pv   = m_valid[cur_line] & m_valid[nxt_line];
            sum      = int'(m_bip) + int'(length);
            exp_new  = bip_bits'(sum % buf_bytes);

            compare_value("packet_out_valid", line_bits'(packet_out_valid),
                          line_bits'(exp_pv));
            compare_value("old_bip", line_bits'(old_bip), line_bits'(m_bip));
            compare_value("new_bip", line_bits'(new_bip), line_bits'(exp_new));
            if (exp_pv) begin
                for (int k = 0; k < line_bytes; k++) begin
                    exp_pkt[8*k +: 8] = mem[bip_bits'((int'(m_bip) + k) % buf_bytes)];
                end
                compare_value("packet_out", packet_out, exp_pkt);
            end

            // init over resteer over branch, then the plain advance
            nxt = m_bip;
            if (is_init) begin
                nxt = init_bip;
            end else if (is_resteer) begin
                nxt = wb_bip;
            end else if (is_branch_taken) begin
                nxt = bp_bip;
            end else if (exp_pv && !stall) begin
                nxt = exp_new;
            end

            if (is_init || is_resteer || is_branch_taken) begin
                m_valid = '0;
            end else if (exp_pv && !stall &&
                         (int'(exp_new) / line_bytes != int'(cur_line))) begin
                m_valid[cur_line] = 1'b0;
            end

            // a fill lands last, so it survives flush and release
            if (fill_strobe) begin
                m_valid[fill_line] = 1'b1;
                for (int k = 0; k < line_bytes; k++) begin
                    mem[bip_bits'(int'(fill_line) * line_bytes + k)] = fill_data[8*k +: 8];
                end
            end
            m_bip = nxt;
        end
    end

endmodule

//--- verification/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

    logic                     clk;
    logic                     reset;
    logic                     fill_strobe;
    logic [line_idx_bits-1:0] fill_line;
    logic [line_bits-1:0]     fill_data;
    logic [len_bits-1:0]      length;
    logic                     stall;
    logic [bip_bits-1:0]      init_bip;
    logic                     is_init;
    logic [bip_bits-1:0]      wb_bip;
    logic                     is_resteer;
    logic [bip_bits-1:0]      bp_bip;
    logic                     is_branch_taken;
    logic [line_bits-1:0]     packet_out;
    logic                     packet_out_valid;
    logic [bip_bits-1:0]      old_bip;
    logic [bip_bits-1:0]      new_bip;

    int check_count;
    int cmp_errors;
    int timeouts;
    int seed;

    typedef struct packed {
        logic                     fill;
        logic [line_idx_bits-1:0] line;
        logic [len_bits-1:0]      len;
        logic                     stall;
        logic [2:0]               cf;         // init, resteer, branch
        logic [bip_bits-1:0]      tgt;
        logic                     wait_valid;
        logic [bip_bits-1:0]      exp_bip;
        logic                     exp_valid;
    } row_t;

    row_t rows[$];

    fetch_top UUT (.*);

    fetch_checker chk (
        .*,
        .check_count (check_count),
        .error_count (cmp_errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic drive_idle();
        fill_strobe     = 1'b0;
        length          = '0;
        stall           = 1'b1;
        is_init         = 1'b0;
        is_resteer      = 1'b0;
        is_branch_taken = 1'b0;
    endtask

    task automatic drive_row(input row_t r);
        fill_strobe = r.fill;
        fill_line   = r.line;
        if (r.fill) begin
            fill_data = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
        length          = r.len;
        stall           = r.stall;
        is_init         = r.cf[2];
        is_resteer      = r.cf[1];
        is_branch_taken = r.cf[0];
        // each source gets its own target so the winner shows in old_bip
        init_bip = r.tgt;
        wb_bip   = r.tgt + bip_bits'(16);
        bp_bip   = r.tgt + bip_bits'(32);
    endtask

    task automatic wait_for_valid(input int row);
        int cycles;
        cycles = 0;
        while (!packet_out_valid && cycles < 20) begin
            drive_idle();
            @(negedge clk);
            cycles++;
        end
        if (!packet_out_valid) begin
            timeouts++;
            $display("timeout: packet_out_valid stayed low before row %0d", row);
        end
    endtask

    task automatic add_row(input int fill, input int line, input int len, input int stl,
                           input int cf, input int tgt, input int wv, input int eb,
                           input int ev);
        row_t r;
        r.fill       = fill[0];
        r.line       = line[1:0];
        r.len        = len[7:0];
        r.stall      = stl[0];
        r.cf         = cf[2:0];
        r.tgt        = tgt[5:0];
        r.wait_valid = wv[0];
        r.exp_bip    = eb[5:0];
        r.exp_valid  = ev[0];
        rows.push_back(r);
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus table
    // fill, line, len, stall, cf, target, wait, expected bip, expected valid
    //////////////////////////////////////////////////////////////////////

    task automatic load_table();
        add_row(1, 0, 0, 1, 3'b000, 'h00, 0, 'h00, 0);
        add_row(1, 1, 0, 1, 3'b000, 'h00, 0, 'h00, 1);
        add_row(1, 2, 0, 1, 3'b000, 'h00, 0, 'h00, 1);
        add_row(1, 3, 0, 1, 3'b000, 'h00, 0, 'h00, 1);
        // lengths 1 to 16 walk the whole ring
        add_row(0, 0, 1, 0, 3'b000, 'h00, 1, 'h01, 1);
        add_row(0, 0, 2, 0, 3'b000, 'h00, 1, 'h03, 1);
        add_row(0, 0, 3, 0, 3'b000, 'h00, 1, 'h06, 1);
        add_row(0, 0, 4, 0, 3'b000, 'h00, 1, 'h0a, 1);
        add_row(0, 0, 5, 0, 3'b000, 'h00, 1, 'h0f, 1);
        add_row(0, 0, 6, 0, 3'b000, 'h00, 1, 'h15, 1);
        add_row(0, 0, 7, 0, 3'b000, 'h00, 1, 'h1c, 1);
        add_row(0, 0, 8, 0, 3'b000, 'h00, 1, 'h24, 1);
        add_row(0, 0, 9, 0, 3'b000, 'h00, 1, 'h2d, 1);
        add_row(0, 0, 10, 0, 3'b000, 'h00, 1, 'h37, 0);
        add_row(1, 0, 0, 1, 3'b000, 'h00, 0, 'h37, 1);
        add_row(0, 0, 11, 0, 3'b000, 'h00, 1, 'h02, 0);
        add_row(1, 1, 0, 1, 3'b000, 'h00, 0, 'h02, 1);
        add_row(1, 2, 0, 1, 3'b000, 'h00, 0, 'h02, 1);
        add_row(0, 0, 12, 0, 3'b000, 'h00, 1, 'h0e, 1);
        add_row(0, 0, 13, 0, 3'b000, 'h00, 1, 'h1b, 1);
        add_row(1, 3, 0, 1, 3'b000, 'h00, 0, 'h1b, 1);
        // stalled rows hold the pointer
        add_row(0, 0, 14, 1, 3'b000, 'h00, 0, 'h1b, 1);
        add_row(0, 0, 15, 1, 3'b000, 'h00, 0, 'h1b, 1);
        add_row(0, 0, 14, 0, 3'b000, 'h00, 1, 'h29, 1);
        add_row(0, 0, 15, 0, 3'b000, 'h00, 1, 'h38, 0);
        add_row(1, 0, 0, 1, 3'b000, 'h00, 0, 'h38, 1);
        add_row(0, 0, 16, 0, 3'b000, 'h00, 1, 'h08, 0);
        add_row(1, 1, 0, 1, 3'b000, 'h00, 0, 'h08, 1);
        // control flow priority and flush
        add_row(0, 0, 3, 0, 3'b111, 'h05, 0, 'h05, 0);
        add_row(1, 0, 0, 1, 3'b000, 'h00, 0, 'h05, 0);
        add_row(1, 1, 0, 1, 3'b000, 'h00, 0, 'h05, 1);
        add_row(0, 0, 3, 0, 3'b011, 'h03, 0, 'h13, 0);
        add_row(1, 1, 0, 1, 3'b000, 'h00, 0, 'h13, 0);
        add_row(1, 2, 0, 1, 3'b000, 'h00, 0, 'h13, 1);
        add_row(0, 0, 3, 0, 3'b101, 'h30, 0, 'h30, 0);
        add_row(0, 0, 3, 0, 3'b110, 'h21, 0, 'h21, 0);
        add_row(0, 0, 3, 1, 3'b001, 'h0c, 0, 'h2c, 0);
        add_row(1, 2, 0, 1, 3'b000, 'h00, 0, 'h2c, 0);
        add_row(1, 3, 0, 1, 3'b000, 'h00, 0, 'h2c, 1);
        // fill in the flush cycle keeps its line
        add_row(1, 0, 0, 1, 3'b100, 'h3a, 0, 'h3a, 0);
        add_row(1, 3, 0, 1, 3'b000, 'h00, 0, 'h3a, 1);
        add_row(0, 0, 9, 0, 3'b000, 'h00, 1, 'h03, 0);
    endtask

    initial begin : stimulus
        row_t r;
        int   assert_fails;
        int   total;
        seed      = 64453;
        timeouts  = 0;
        reset     = 1'b1;
        fill_line = '0;
        fill_data = '0;
        init_bip  = '0;
        wb_bip    = '0;
        bp_bip    = '0;
        drive_idle();
        load_table();

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        foreach (rows[i]) begin
            r = rows[i];
            if (r.wait_valid) begin
                wait_for_valid(i);
            end
            drive_row(r);
            @(negedge clk);
            chk.check_row(i, r.exp_bip, r.exp_valid);
        end

        drive_idle();
        @(negedge clk);

        assert_fails = UUT.u_fetch_pointer.u_props.fail_count;
        total        = cmp_errors + timeouts + assert_fails;
        $display("checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
                 check_count, cmp_errors, timeouts, assert_fails);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- build.f
src/fetch_pkg.sv
src/ibuf_if.sv
src/instr_buffer.sv
src/fetch_pointer.sv
src/byte_rotator.sv
src/fetch_top.sv
verification/fetch_props.sv
verification/fetch_checker.sv
verification/fetch_tb.sv

//--- Makefile
TOP := fetch_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f build.f

sim:
	verilator --binary --assert --timing -j 0 --top-module $(TOP) -f build.f -o fetch_sim
	@out="$$(./obj_dir/fetch_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
